/* design/gpio_sys_pkg.sv */
package gpio_sys_pkg;

	// APB bus widths
	localparam int addr_w = 32;
	localparam int data_w = 32;

	// pins per GPIO port
	localparam int port_w = 8;

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [data_w-1:0] data_word_t;
	typedef logic [port_w-1:0] port_data_t;

	// subsystem region, one 64 KiB window per port
	localparam addr_t sys_base = 32'h4000_0000;
	localparam int win_bits = 16;
	localparam int max_ports = 16;
	localparam int idx_w = $clog2(max_ports);

	// base is compared above the port index field, i.e. bits 31:20
	localparam int base_lsb = win_bits + idx_w;

	typedef logic [idx_w-1:0] port_idx_t;

	// register word index sits in paddr[4:2]
	localparam int reg_lsb = 2;
	localparam int reg_w = 3;

	typedef enum logic [reg_w-1:0] {
		reg_data_in    = 3'd0,
		reg_data_out   = 3'd1,
		reg_dir        = 3'd2,
		reg_irq_mask   = 3'd3,
		reg_irq_status = 3'd4
	} gpio_reg_e;

endpackage

/* design/apb_port_decoder.sv */
`timescale 1ns/100ps

module apb_port_decoder
	import gpio_sys_pkg::*;
#(
	parameter int N_PORTS = 4
) (
	input  addr_t              paddr,
	input  logic               psel,
	input  logic               penable,
	output logic [N_PORTS-1:0] port_sel,
	output gpio_reg_e          offset,
	output logic               miss
);

	logic      base_hit;
	port_idx_t port_idx;
	logic      any_sel;

	// upper address bits must land in the subsystem region
	assign base_hit = (paddr[addr_w-1:base_lsb] == sys_base[addr_w-1:base_lsb]);

	// window number picks the port
	assign port_idx = paddr[win_bits +: idx_w];

	// one compare per existing port
	// an index of N_PORTS or more matches nothing and ends up as a miss
	genvar i;
	generate
		for (i = 0; i < N_PORTS; i++) begin : g_sel
			assign port_sel[i] = psel && base_hit && (port_idx == port_idx_t'(i));
		end
	endgenerate

	assign any_sel = |port_sel;

	// only flagged in the access phase, where pslverr is sampled
	assign miss = psel && penable && !any_sel;

	// register word inside the window, shared by all ports
	assign offset = gpio_reg_e'(paddr[reg_lsb +: reg_w]);

endmodule

/* design/gpio8_port.sv */
`timescale 1ns/100ps

module gpio8_port
	import gpio_sys_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	// request side, already decoded
	input  logic       sel,
	input  logic       penable,
	input  logic       pwrite,
	input  gpio_reg_e  offset,
	input  data_word_t pwdata,

	// response side
	output data_word_t rdata,
	output logic       err,

	// pads
	input  port_data_t pins_in,
	output port_data_t pins_out,
	output port_data_t pins_oe,
	output logic       irq
);

	// input synchronizer and edge history
	port_data_t sync_q1;
	port_data_t sync_q2;
	port_data_t prev_q;

	// software visible registers
	port_data_t data_out_q;
	port_data_t dir_q;
	port_data_t mask_q;
	port_data_t status_q;

	port_data_t rise;
	port_data_t clr;

	logic       access;
	logic       acc_bad;
	logic       wr_en;
	data_word_t rd_word;

	assign access = sel && penable;

	// register decode for both directions
	always_comb begin
		acc_bad = 1'b0;
		rd_word = '0;
		case (offset)
			reg_data_in: begin
				rd_word = data_word_t'(sync_q2);
				// read only
				acc_bad = pwrite;
			end
			reg_data_out: begin
				rd_word = data_word_t'(data_out_q);
			end
			reg_dir: begin
				rd_word = data_word_t'(dir_q);
			end
			reg_irq_mask: begin
				rd_word = data_word_t'(mask_q);
			end
			reg_irq_status: begin
				rd_word = data_word_t'(status_q);
			end
			default: begin
				acc_bad = 1'b1;
			end
		endcase
	end

	// a rejected access changes nothing and returns zero
	assign wr_en = access && pwrite && !acc_bad;
	assign err = access && acc_bad;
	assign rdata = (access && !pwrite && !acc_bad) ? rd_word : '0;

	// two flops against metastability, third one for edge detection
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
			prev_q <= '0;
		end else begin
			sync_q1 <= pins_in;
			sync_q2 <= sync_q1;
			prev_q <= sync_q2;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_out_q <= '0;
			dir_q <= '0;
			mask_q <= '0;
		end else if (wr_en) begin
			case (offset)
				reg_data_out: data_out_q <= pwdata[port_w-1:0];
				reg_dir: dir_q <= pwdata[port_w-1:0];
				reg_irq_mask: mask_q <= pwdata[port_w-1:0];
				default: ;
			endcase
		end
	end

	// rising edges only, falling edges are ignored
	assign rise = sync_q2 & ~prev_q;

	// write one to clear
	assign clr = (wr_en && (offset == reg_irq_status)) ? pwdata[port_w-1:0] : '0;

	// new edge wins over a clear in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			status_q <= '0;
		end else begin
			status_q <= (status_q & ~clr) | rise;
		end
	end

	assign pins_out = data_out_q;
	assign pins_oe = dir_q;
	assign irq = |(status_q & mask_q);

endmodule

/* design/apb_response_mux.sv */
`timescale 1ns/100ps

module apb_response_mux
	import gpio_sys_pkg::*;
#(
	parameter int N_PORTS = 4
) (
	input  logic                     psel,
	input  logic                     penable,

	// per port responses
	input  data_word_t [N_PORTS-1:0] port_rdata,
	input  logic [N_PORTS-1:0]       port_err,

	// no port claimed the address
	input  logic                     miss,

	output logic                     pready,
	output data_word_t               prdata,
	output logic                     pslverr
);

	data_word_t rdata_or;
	logic       any_err;

	// unselected ports drive zero, so a plain OR picks the active one
	always_comb begin
		rdata_or = '0;
		for (int i = 0; i < N_PORTS; i++) begin
			rdata_or = rdata_or | port_rdata[i];
		end
	end

	assign any_err = |port_err;

	// no wait states
	assign pready = psel && penable;

	assign prdata = rdata_or;

	// port errors and misses are both access-phase only
	assign pslverr = any_err || miss;

endmodule

/* design/gpio_apb_sys.sv */
`timescale 1ns/100ps

module gpio_apb_sys
	import gpio_sys_pkg::*;
#(
	parameter int N_PORTS = 4
) (
	input  logic                     clk,
	input  logic                     rst_n,

	// APB completer
	input  addr_t                    paddr,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  data_word_t               pwdata,
	output logic                     pready,
	output data_word_t               prdata,
	output logic                     pslverr,

	// pads, entry i belongs to port i
	input  port_data_t [N_PORTS-1:0] gpio_in,
	output port_data_t [N_PORTS-1:0] gpio_out,
	output port_data_t [N_PORTS-1:0] gpio_oe,
	output logic [N_PORTS-1:0]       irq
);

	logic [N_PORTS-1:0]       port_sel;
	logic                     miss;
	gpio_reg_e                offset;
	data_word_t [N_PORTS-1:0] port_rdata;
	logic [N_PORTS-1:0]       port_err;

	apb_port_decoder #(
		.N_PORTS (N_PORTS)
	) u_decoder (
		.paddr    (paddr),
		.psel     (psel),
		.penable  (penable),
		.port_sel (port_sel),
		.offset   (offset),
		.miss     (miss)
	);

	// identical ports, each in its own 64 KiB window
	genvar i;
	generate
		for (i = 0; i < N_PORTS; i++) begin : g_port
			gpio8_port u_port (
				.clk      (clk),
				.rst_n    (rst_n),
				.sel      (port_sel[i]),
				.penable  (penable),
				.pwrite   (pwrite),
				.offset   (offset),
				.pwdata   (pwdata),
				.rdata    (port_rdata[i]),
				.err      (port_err[i]),
				.pins_in  (gpio_in[i]),
				.pins_out (gpio_out[i]),
				.pins_oe  (gpio_oe[i]),
				.irq      (irq[i])
			);
		end
	endgenerate

	apb_response_mux #(
		.N_PORTS (N_PORTS)
	) u_resp_mux (
		.psel       (psel),
		.penable    (penable),
		.port_rdata (port_rdata),
		.port_err   (port_err),
		.miss       (miss),
		.pready     (pready),
		.prdata     (prdata),
		.pslverr    (pslverr)
	);

endmodule

/* test/gpio_apb_sys_asserts.sv */
`timescale 1ns/100ps

module gpio_apb_sys_asserts
	import gpio_sys_pkg::*;
#(
	parameter int N_PORTS = 4
) (
	input logic                     clk,
	input logic                     rst_n,
	input logic                     psel,
	input logic                     penable,
	input logic                     pready,
	input logic                     pslverr,
	input port_data_t [N_PORTS-1:0] gpio_out,
	input port_data_t [N_PORTS-1:0] gpio_oe,
	input logic [N_PORTS-1:0]       irq
);

	// access phase always comes right after a setup cycle
	a_pready_access: assert property (@(posedge clk) disable iff (!rst_n)
		pready |-> (psel && penable && $past(psel && !penable)))
		else $error("pready high outside an access phase");

	a_slverr_ready: assert property (@(posedge clk) disable iff (!rst_n)
		pslverr |-> pready) else $error("pslverr high without pready");

	// pads and interrupts quiet during reset
	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |-> (gpio_out == '0 && gpio_oe == '0 && irq == '0))
		else $error("outputs active while in reset");

endmodule

bind gpio_apb_sys gpio_apb_sys_asserts #(.N_PORTS(N_PORTS)) u_asserts (.*);

/* test/tb_gpio_apb_sys.sv */
`timescale 1ns/100ps

module tb_gpio_apb_sys
	import gpio_sys_pkg::*;
();

	localparam int n_ports = 4;
	localparam int max_wait = 16;

	// byte offsets inside a port window
	localparam logic [4:0] off_in = 5'h00;
	localparam logic [4:0] off_out = 5'h04;
	localparam logic [4:0] off_dir = 5'h08;
	localparam logic [4:0] off_mask = 5'h0C;
	localparam logic [4:0] off_stat = 5'h10;

	// op_pins drives wdata onto the port pins, then polls reg_data_in
	typedef enum {op_write, op_read, op_pins, op_irq} tb_op_e;

	logic                     clk;
	logic                     rst_n;
	addr_t                    paddr;
	logic                     psel;
	logic                     penable;
	logic                     pwrite;
	data_word_t               pwdata;
	logic                     pready;
	data_word_t               prdata;
	logic                     pslverr;
	port_data_t [n_ports-1:0] gpio_in;
	port_data_t [n_ports-1:0] gpio_out;
	port_data_t [n_ports-1:0] gpio_oe;
	logic [n_ports-1:0]       irq;

	// stimulus table
	string      t_name[$];
	tb_op_e     t_op[$];
	addr_t      t_addr[$];
	data_word_t t_wdata[$];
	data_word_t t_exp[$];
	logic       t_err[$];

	// pad state the ports should show
	port_data_t exp_out [n_ports];
	port_data_t exp_oe [n_ports];
	integer     seed;

	gpio_apb_sys #(.N_PORTS(n_ports)) u_gpio_apb_sys (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_run();
		$display("TB FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_word(input string name, input data_word_t exp, input data_word_t act);
		if (act !== exp) begin
			$display("ERROR %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_pins(input string name, input port_data_t exp, input port_data_t act);
		if (act !== exp) begin
			$display("ERROR %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR %s expected %b actual %b", name, exp, act);
			stop_run();
		end
	endtask

	// setup cycle, then access cycle until pready
	task automatic apb_access(input addr_t addr, input logic wr, input data_word_t wdata,
			output data_word_t rdata, output logic err);
		int waited;
		waited = 0;
		@(posedge clk);
		paddr <= addr;
		pwrite <= wr;
		pwdata <= wdata;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready && waited < max_wait) begin
			@(negedge clk);
			waited++;
		end
		if (!pready) begin
			$display("pready never came for the transfer to address %h", addr);
			stop_run();
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	function automatic addr_t reg_addr(input int port, input logic [4:0] off);
		return sys_base | (addr_t'(port) << win_bits) | addr_t'(off);
	endfunction

	task automatic add_entry(input string name, input tb_op_e op, input addr_t addr,
			input data_word_t wdata, input data_word_t exp, input logic err);
		t_name.push_back(name);
		t_op.push_back(op);
		t_addr.push_back(addr);
		t_wdata.push_back(wdata);
		t_exp.push_back(exp);
		t_err.push_back(err);
	endtask

	initial begin
		data_word_t rd;
		logic       err;
		port_data_t vo;
		port_data_t rnd;
		int         p;
		int         r;
		int         k;
		int         tries;
		string      nm;

		rst_n = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		gpio_in = '0;
		seed = 43622;
		for (p = 0; p < n_ports; p++) begin
			exp_out[p] = '0;
			exp_oe[p] = '0;
		end

		// every register of every port reads zero after reset
		for (p = 0; p < n_ports; p++)
			for (r = 0; r < 5; r++)
				add_entry($sformatf("reset_p%0d_r%0d", p, r), op_read, reg_addr(p, 5'(r * 4)),
					'0, '0, 1'b0);
		for (p = 0; p < n_ports; p++) begin
			vo = 8'h5A ^ port_data_t'(p * 17);
			add_entry($sformatf("out_wr_p%0d", p), op_write, reg_addr(p, off_out), vo, '0, 1'b0);
			add_entry($sformatf("dir_wr_p%0d", p), op_write, reg_addr(p, off_dir),
				port_data_t'(~vo), '0, 1'b0);
			add_entry($sformatf("out_rd_p%0d", p), op_read, reg_addr(p, off_out), '0, vo, 1'b0);
			add_entry($sformatf("dir_rd_p%0d", p), op_read, reg_addr(p, off_dir), '0,
				port_data_t'(~vo), 1'b0);
		end
		for (p = 0; p < n_ports; p++) begin
			rnd = port_data_t'($random(seed));
			add_entry($sformatf("pins_p%0d", p), op_pins, reg_addr(p, off_in), rnd, rnd, 1'b0);
		end
		// edge interrupt on port 2, pin 3
		add_entry("irq_pins_low", op_pins, reg_addr(2, off_in), 32'h00, 32'h00, 1'b0);
		add_entry("irq_clear_all", op_write, reg_addr(2, off_stat), 32'hFF, '0, 1'b0);
		add_entry("irq_status_idle", op_read, reg_addr(2, off_stat), '0, 32'h00, 1'b0);
		add_entry("irq_pin_rise", op_pins, reg_addr(2, off_in), 32'h08, 32'h08, 1'b0);
		add_entry("irq_status_set", op_read, reg_addr(2, off_stat), '0, 32'h08, 1'b0);
		add_entry("irq_masked", op_irq, reg_addr(2, off_stat), '0, 32'h0, 1'b0);
		add_entry("irq_mask_wr", op_write, reg_addr(2, off_mask), 32'h08, '0, 1'b0);
		add_entry("irq_mask_rd", op_read, reg_addr(2, off_mask), '0, 32'h08, 1'b0);
		add_entry("irq_raised", op_irq, reg_addr(2, off_stat), '0, 32'h1, 1'b0);
		add_entry("irq_w1c", op_write, reg_addr(2, off_stat), 32'h08, '0, 1'b0);
		add_entry("irq_status_clr", op_read, reg_addr(2, off_stat), '0, 32'h00, 1'b0);
		add_entry("irq_dropped", op_irq, reg_addr(2, off_stat), '0, 32'h0, 1'b0);
		add_entry("irq_pin_fall", op_pins, reg_addr(2, off_in), 32'h00, 32'h00, 1'b0);
		add_entry("irq_no_fall_set", op_read, reg_addr(2, off_stat), '0, 32'h00, 1'b0);
		// rejected accesses
		add_entry("undef_rd", op_read, reg_addr(0, 5'h14), '0, '0, 1'b1);
		add_entry("undef_wr", op_write, reg_addr(1, 5'h1C), 32'hFF, '0, 1'b1);
		add_entry("data_in_wr", op_write, reg_addr(0, off_in), 32'hFF, '0, 1'b1);
		add_entry("base_miss_wr", op_write, 32'h5000_0004, 32'h00, '0, 1'b1);
		add_entry("base_miss_rd", op_read, 32'h3000_0004, '0, '0, 1'b1);
		add_entry("index_miss_wr", op_write, reg_addr(n_ports, off_dir), 32'h00, '0, 1'b1);
		add_entry("index_miss_rd", op_read, reg_addr(15, off_out), '0, '0, 1'b1);
		add_entry("out_kept_p1", op_read, reg_addr(1, off_out), '0, 32'h5A ^ 32'h11, 1'b0);

		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		for (p = 0; p < n_ports; p++) begin
			check_pins($sformatf("reset gpio_out%0d", p), '0, gpio_out[p]);
			check_pins($sformatf("reset gpio_oe%0d", p), '0, gpio_oe[p]);
			check_flag($sformatf("reset irq%0d", p), 1'b0, irq[p]);
		end

		for (k = 0; k < t_name.size(); k++) begin
			p = int'(t_addr[k][19:16]);
			nm = t_name[k];
			case (t_op[k])
				op_write, op_read: begin
					apb_access(t_addr[k], t_op[k] == op_write, t_wdata[k], rd, err);
					check_flag(nm, t_err[k], err);
					if (t_op[k] == op_read)
						check_word(nm, t_exp[k], rd);
					// accepted writes to the pad registers move the pads
					if (t_op[k] == op_write && !t_err[k] && t_addr[k][4:0] == off_out)
						exp_out[p] = t_wdata[k][port_w-1:0];
					if (t_op[k] == op_write && !t_err[k] && t_addr[k][4:0] == off_dir)
						exp_oe[p] = t_wdata[k][port_w-1:0];
				end
				op_pins: begin
					@(posedge clk);
					gpio_in[p] <= t_wdata[k][port_w-1:0];
					tries = 0;
					apb_access(t_addr[k], 1'b0, '0, rd, err);
					while (rd !== t_exp[k] && tries < max_wait) begin
						apb_access(t_addr[k], 1'b0, '0, rd, err);
						tries++;
					end
					if (rd !== t_exp[k])
						$display("pins of port %0d never reached reg_data_in", p);
					check_flag(nm, 1'b0, err);
					check_word(nm, t_exp[k], rd);
				end
				op_irq: begin
					tries = 0;
					@(negedge clk);
					while (irq[p] !== t_exp[k][0] && tries < max_wait) begin
						@(negedge clk);
						tries++;
					end
					if (irq[p] !== t_exp[k][0])
						$display("irq of port %0d did not reach its expected level", p);
					check_flag(nm, t_exp[k][0], irq[p]);
				end
				default: ;
			endcase
			@(negedge clk);
			for (r = 0; r < n_ports; r++) begin
				check_pins($sformatf("%s gpio_out%0d", nm, r), exp_out[r], gpio_out[r]);
				check_pins($sformatf("%s gpio_oe%0d", nm, r), exp_oe[r], gpio_oe[r]);
			end
		end

		$display("TB PASSED");
		$finish;
	end

endmodule

/* files.f */
design/gpio_sys_pkg.sv
design/apb_port_decoder.sv
design/gpio8_port.sv
design/apb_response_mux.sv
design/gpio_apb_sys.sv
test/gpio_apb_sys_asserts.sv
test/tb_gpio_apb_sys.sv
